/* hdl/mips_pkg.sv */
package mips_pkg;

   // machine word and register index widths
   localparam int XLEN   = 32;
   localparam int REG_AW = 5;

   // reset pc, start of the text segment
   localparam logic [XLEN-1:0] TEXT_START = 32'h0040_0000;

   // primary opcodes of the kept subset
   localparam logic [5:0] OP_SPECIAL = 6'h00;
   localparam logic [5:0] OP_J       = 6'h02;
   localparam logic [5:0] OP_BEQ     = 6'h04;
   localparam logic [5:0] OP_BNE     = 6'h05;
   localparam logic [5:0] OP_ADDIU   = 6'h09;
   localparam logic [5:0] OP_ORI     = 6'h0d;
   localparam logic [5:0] OP_LUI     = 6'h0f;
   localparam logic [5:0] OP_LW      = 6'h23;
   localparam logic [5:0] OP_SW      = 6'h2b;

   // funct codes under OP_SPECIAL
   localparam logic [5:0] FN_SYSCALL = 6'h0c;
   localparam logic [5:0] FN_ADDU    = 6'h21;
   localparam logic [5:0] FN_SUBU    = 6'h23;
   localparam logic [5:0] FN_AND     = 6'h24;
   localparam logic [5:0] FN_OR      = 6'h25;
   localparam logic [5:0] FN_XOR     = 6'h26;
   localparam logic [5:0] FN_NOR     = 6'h27;
   localparam logic [5:0] FN_SLT     = 6'h2a;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_NOR,
      ALU_SLT,
      ALU_LUI
   } alu_op_e;

   // register format
   typedef struct packed {
      logic [5:0]        op;
      logic [REG_AW-1:0] rs;
      logic [REG_AW-1:0] rt;
      logic [REG_AW-1:0] rd;
      logic [4:0]        shamt;
      logic [5:0]        funct;
   } inst_r_t;

   // immediate format, also loads, stores and branches
   typedef struct packed {
      logic [5:0]        op;
      logic [REG_AW-1:0] rs;
      logic [REG_AW-1:0] rt;
      logic [15:0]       imm;
   } inst_i_t;

   typedef struct packed {
      logic [5:0]  op;
      logic [25:0] target;
   } inst_j_t;

   // one instruction word seen through the three formats
   typedef union packed {
      inst_r_t r;
      inst_i_t i;
      inst_j_t j;
   } inst_t;

   typedef struct packed {
      logic [XLEN-1:0] addr;
      logic            write;
      logic [XLEN-1:0] wdata;
   } bus_req_t;

   typedef struct packed {
      logic            done;
      logic [XLEN-1:0] rdata;
   } bus_rsp_t;

endpackage

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu
(
   input  mips_pkg::alu_op_e         op,
   input  logic [mips_pkg::XLEN-1:0] a,
   input  logic [mips_pkg::XLEN-1:0] b,
   output logic [mips_pkg::XLEN-1:0] y,
   output logic                      zero
);

   localparam int HALF = mips_pkg::XLEN / 2;

   logic lt;

   // two's complement compare for slt
   assign lt = $signed(a) < $signed(b);

   always_comb
   begin
      case (op)
         mips_pkg::ALU_ADD:
            y = a + b;
         mips_pkg::ALU_SUB:
            y = a - b;
         mips_pkg::ALU_AND:
            y = a & b;
         mips_pkg::ALU_OR:
            y = a | b;
         mips_pkg::ALU_XOR:
            y = a ^ b;
         mips_pkg::ALU_NOR:
            y = ~(a | b);
         mips_pkg::ALU_SLT:
            y = {{(mips_pkg::XLEN-1){1'b0}}, lt};
         // immediate into the upper half, lower half cleared
         mips_pkg::ALU_LUI:
            y = {b[HALF-1:0], {HALF{1'b0}}};
         default:
            y = '0;
      endcase
   end

   // branch equality test
   assign zero = (y == '0);

endmodule

/* hdl/regfile.sv */
`timescale 1ns/1ps

module regfile
(
   input  logic                        clk,
   input  logic                        rst_b,
   input  logic [mips_pkg::REG_AW-1:0] rs_idx,
   input  logic [mips_pkg::REG_AW-1:0] rt_idx,
   input  logic [mips_pkg::REG_AW-1:0] wr_idx,
   output logic [mips_pkg::XLEN-1:0]   rs_data,
   output logic [mips_pkg::XLEN-1:0]   rt_data,
   input  logic                        wr_en,
   input  logic [mips_pkg::XLEN-1:0]   wr_data
);

   logic [mips_pkg::XLEN-1:0] regs [2**mips_pkg::REG_AW];

   // r0 is cleared here and never written, so it always reads zero
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         for (int k = 0; k < 2**mips_pkg::REG_AW; k++)
            regs[k] <= '0;
      end
      else if (wr_en && (wr_idx != '0))
         regs[wr_idx] <= wr_data;
   end

   // reads are combinational
   assign rs_data = regs[rs_idx];
   assign rt_data = regs[rt_idx];

endmodule

/* hdl/lsu.sv */
`timescale 1ns/1ps

module lsu
(
   input  logic               clk,
   input  logic               rst_b,
   input  logic               mem_valid,
   input  mips_pkg::bus_req_t mem_req,
   output mips_pkg::bus_rsp_t mem_rsp,
   output logic               bus_valid,
   output mips_pkg::bus_req_t bus_req,
   input  mips_pkg::bus_rsp_t bus_rsp
);

   logic                      busy;
   logic                      accept;
   logic                      done_q;
   mips_pkg::bus_req_t        req_q;
   logic [mips_pkg::XLEN-1:0] rdata_q;

   assign accept = mem_valid && !busy;

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         busy   <= 1'b0;
         done_q <= 1'b0;
      end
      else
      begin
         if (accept)
            busy <= 1'b1;
         else if (bus_rsp.done)
            busy <= 1'b0;
         // done back to control one cycle after the bus
         done_q <= bus_rsp.done;
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
         req_q <= mem_req;
      if (bus_rsp.done)
         rdata_q <= bus_rsp.rdata;
   end

   assign bus_valid     = busy;
   assign bus_req       = req_q;
   assign mem_rsp.done  = done_q;
   assign mem_rsp.rdata = rdata_q;

   // control waits for done before it issues the next access
   a_no_overlap: assert property (@(posedge clk) disable iff (!rst_b)
      mem_valid |-> !busy);

endmodule

/* hdl/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit
(
   input  logic                      clk,
   input  logic                      rst_b,
   output logic                      bus_valid,
   output mips_pkg::bus_req_t        bus_req,
   input  mips_pkg::bus_rsp_t        bus_rsp,
   output logic                      inst_valid,
   output mips_pkg::inst_t           inst,
   output logic [mips_pkg::XLEN-1:0] inst_pc,
   input  logic                      inst_ready,
   input  logic                      redirect,
   input  logic [mips_pkg::XLEN-1:0] redirect_pc
);

   // next word to request
   logic [mips_pkg::XLEN-1:0] fetch_pc;
   // word currently on the bus
   logic [mips_pkg::XLEN-1:0] req_addr;
   logic                      pend;
   // outstanding transfer made stale by a redirect
   logic                      drop;
   logic                      buf_valid;
   mips_pkg::inst_t           buf_word;
   logic [mips_pkg::XLEN-1:0] buf_pc;
   logic                      take;
   logic                      launch;
   logic                      keep;

   assign take   = buf_valid && inst_ready;
   // the buffer is the prefetch slot, refill once it frees up
   assign launch = !pend && (!buf_valid || take || redirect);
   assign keep   = bus_rsp.done && !drop && !redirect;

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         fetch_pc  <= mips_pkg::TEXT_START;
         pend      <= 1'b0;
         drop      <= 1'b0;
         buf_valid <= 1'b0;
      end
      else
      begin
         if (launch)
            pend <= 1'b1;
         else if (bus_rsp.done)
            pend <= 1'b0;
         // let the stale transfer finish, then forget it
         if (redirect && pend && !bus_rsp.done)
            drop <= 1'b1;
         else if (bus_rsp.done)
            drop <= 1'b0;
         if (redirect)
            fetch_pc <= redirect_pc;
         else if (keep)
            fetch_pc <= req_addr + 4;
         if (redirect || take)
            buf_valid <= 1'b0;
         else if (keep)
            buf_valid <= 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (launch)
         req_addr <= redirect ? redirect_pc : fetch_pc;
      if (keep)
      begin
         buf_word <= bus_rsp.rdata;
         buf_pc   <= req_addr;
      end
   end

   assign bus_valid     = pend;
   assign bus_req.addr  = req_addr;
   assign bus_req.write = 1'b0;
   assign bus_req.wdata = '0;
   assign inst_valid    = buf_valid;
   assign inst          = buf_word;
   assign inst_pc       = buf_pc;

   // nothing from the old path reaches decode after a redirect
   a_redirect_flush: assert property (@(posedge clk) disable iff (!rst_b)
      redirect |=> !inst_valid);

endmodule

/* hdl/apb_arbiter.sv */
`timescale 1ns/1ps

module apb_arbiter
(
   input  logic                      clk,
   input  logic                      rst_b,
   input  logic                      fetch_valid,
   input  mips_pkg::bus_req_t        fetch_req,
   output mips_pkg::bus_rsp_t        fetch_rsp,
   input  logic                      data_valid,
   input  mips_pkg::bus_req_t        data_req,
   output mips_pkg::bus_rsp_t        data_rsp,
   output logic [mips_pkg::XLEN-1:0] paddr,
   output logic                      pwrite,
   output logic [mips_pkg::XLEN-1:0] pwdata,
   output logic                      psel,
   output logic                      penable,
   input  logic [mips_pkg::XLEN-1:0] prdata,
   input  logic                      pready
);

   typedef enum logic [1:0] {ST_IDLE, ST_SETUP, ST_ACCESS} apb_state_e;

   apb_state_e         state;
   // owner of the current transfer, high for the data side
   logic               gnt_data;
   // request copy driven onto the bus
   mips_pkg::bus_req_t cur;
   logic               xfer_end;

   assign xfer_end = (state == ST_ACCESS) && pready;

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         state    <= ST_IDLE;
         gnt_data <= 1'b0;
      end
      else
      begin
         case (state)
            ST_IDLE:
            begin
               // arbitration only here, data side wins a tie
               if (data_valid || fetch_valid)
               begin
                  state    <= ST_SETUP;
                  gnt_data <= data_valid;
               end
            end
            ST_SETUP:
               state <= ST_ACCESS;
            default:
            begin
               // wait states keep us here
               if (pready)
                  state <= ST_IDLE;
            end
         endcase
      end
   end

   // sampled only while idle so the transfer fields stay frozen
   always_ff @(posedge clk)
   begin
      if (state == ST_IDLE)
         cur <= data_valid ? data_req : fetch_req;
   end

   assign psel    = (state != ST_IDLE);
   assign penable = (state == ST_ACCESS);
   assign paddr   = cur.addr;
   assign pwrite  = cur.write;
   assign pwdata  = cur.wdata;

   // done goes only to the owner, read data is shared
   assign data_rsp.done   = xfer_end && gnt_data;
   assign data_rsp.rdata  = prdata;
   assign fetch_rsp.done  = xfer_end && !gnt_data;
   assign fetch_rsp.rdata = prdata;

   // no access phase outside a selected transfer
   a_enable_sel: assert property (@(posedge clk) disable iff (!rst_b)
      penable |-> psel);

   // address and data hold through the wait states
   a_stable_access: assert property (@(posedge clk) disable iff (!rst_b)
      penable |-> $stable(paddr) && $stable(pwrite) && $stable(pwdata));

endmodule

/* hdl/core_ctrl.sv */
`timescale 1ns/1ps

module core_ctrl
(
   input  logic                        clk,
   input  logic                        rst_b,
   input  logic                        inst_valid,
   input  mips_pkg::inst_t             inst,
   input  logic [mips_pkg::XLEN-1:0]   inst_pc,
   output logic                        inst_ready,
   output logic                        redirect,
   output logic [mips_pkg::XLEN-1:0]   redirect_pc,
   output logic                        mem_valid,
   output mips_pkg::bus_req_t          mem_req,
   input  mips_pkg::bus_rsp_t          mem_rsp,
   output logic [mips_pkg::REG_AW-1:0] rs_idx,
   output logic [mips_pkg::REG_AW-1:0] rt_idx,
   output logic [mips_pkg::REG_AW-1:0] wr_idx,
   input  logic [mips_pkg::XLEN-1:0]   rs_data,
   input  logic [mips_pkg::XLEN-1:0]   rt_data,
   output logic                        wr_en,
   output logic [mips_pkg::XLEN-1:0]   wr_data,
   output mips_pkg::alu_op_e           alu_op,
   output logic [mips_pkg::XLEN-1:0]   alu_a,
   output logic [mips_pkg::XLEN-1:0]   alu_b,
   input  logic [mips_pkg::XLEN-1:0]   alu_y,
   input  logic                        alu_zero,
   output logic                        halted
);

   typedef enum logic [1:0] {S_WAIT, S_EXEC, S_MEM, S_WB} state_e;

   state_e                    state;
   // instruction in flight and its address
   mips_pkg::inst_t           ir;
   logic [mips_pkg::XLEN-1:0] pc_q;
   logic [mips_pkg::XLEN-1:0] ld_q;
   logic [mips_pkg::XLEN-1:0] pc4;
   logic [mips_pkg::XLEN-1:0] simm;
   logic [mips_pkg::XLEN-1:0] zimm;
   logic                      accept;
   logic                      is_r;
   logic                      is_lw;
   logic                      is_sw;
   logic                      is_j;
   logic                      reg_wr;
   logic                      taken;

   assign accept = inst_valid && inst_ready;
   assign is_r   = (ir.r.op == mips_pkg::OP_SPECIAL);
   assign is_lw  = (ir.i.op == mips_pkg::OP_LW);
   assign is_sw  = (ir.i.op == mips_pkg::OP_SW);
   assign is_j   = (ir.j.op == mips_pkg::OP_J);
   assign simm   = {{16{ir.i.imm[15]}}, ir.i.imm};
   assign zimm   = {16'h0000, ir.i.imm};
   assign pc4    = pc_q + 4;

   // operand b and result routing per opcode, unknown opcodes fall through as no-ops
   always_comb
   begin
      alu_op = mips_pkg::ALU_ADD;
      alu_b  = simm;
      reg_wr = 1'b0;
      case (ir.r.op)
         mips_pkg::OP_SPECIAL:
         begin
            alu_b  = rt_data;
            reg_wr = 1'b1;
            case (ir.r.funct)
               mips_pkg::FN_ADDU:
                  alu_op = mips_pkg::ALU_ADD;
               mips_pkg::FN_SUBU:
                  alu_op = mips_pkg::ALU_SUB;
               mips_pkg::FN_AND:
                  alu_op = mips_pkg::ALU_AND;
               mips_pkg::FN_OR:
                  alu_op = mips_pkg::ALU_OR;
               mips_pkg::FN_XOR:
                  alu_op = mips_pkg::ALU_XOR;
               mips_pkg::FN_NOR:
                  alu_op = mips_pkg::ALU_NOR;
               mips_pkg::FN_SLT:
                  alu_op = mips_pkg::ALU_SLT;
               // syscall and the rest write nothing
               default:
                  reg_wr = 1'b0;
            endcase
         end
         mips_pkg::OP_ADDIU, mips_pkg::OP_LW:
            reg_wr = 1'b1;
         mips_pkg::OP_ORI:
         begin
            alu_op = mips_pkg::ALU_OR;
            alu_b  = zimm;
            reg_wr = 1'b1;
         end
         mips_pkg::OP_LUI:
         begin
            alu_op = mips_pkg::ALU_LUI;
            alu_b  = zimm;
            reg_wr = 1'b1;
         end
         // compare by subtraction, zero flag decides
         mips_pkg::OP_BEQ, mips_pkg::OP_BNE:
         begin
            alu_op = mips_pkg::ALU_SUB;
            alu_b  = rt_data;
         end
         default:
            reg_wr = 1'b0;
      endcase
   end

   assign alu_a  = rs_data;
   assign rs_idx = ir.r.rs;
   assign rt_idx = ir.r.rt;
   assign wr_idx = is_r ? ir.r.rd : ir.r.rt;

   // regs and ir are unchanged since execute, so the compare is still valid here
   assign taken = ((ir.i.op == mips_pkg::OP_BEQ) && alu_zero)
                  || ((ir.i.op == mips_pkg::OP_BNE) && !alu_zero)
                  || is_j;
   assign redirect_pc = is_j ? {pc4[mips_pkg::XLEN-1:28], ir.j.target, 2'b00}
                             : pc4 + {simm[mips_pkg::XLEN-3:0], 2'b00};

   assign inst_ready = (state == S_WAIT) && !halted;
   assign redirect   = (state == S_WB) && taken;
   assign wr_en      = (state == S_WB) && reg_wr;
   assign wr_data    = is_lw ? ld_q : alu_y;

   // one strobe per access, the lsu holds it
   assign mem_valid     = (state == S_EXEC) && (is_lw || is_sw);
   assign mem_req.addr  = alu_y;
   assign mem_req.write = is_sw;
   assign mem_req.wdata = rt_data;

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         state  <= S_WAIT;
         halted <= 1'b0;
      end
      else
      begin
         case (state)
            S_WAIT:
            begin
               if (accept)
                  state <= S_EXEC;
            end
            S_EXEC:
               state <= mem_valid ? S_MEM : S_WB;
            S_MEM:
            begin
               if (mem_rsp.done)
                  state <= S_WB;
            end
            default:
            begin
               state <= S_WAIT;
               // syscall retires here and parks the core
               if (is_r && (ir.r.funct == mips_pkg::FN_SYSCALL))
                  halted <= 1'b1;
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         ir   <= inst;
         pc_q <= inst_pc;
      end
      if (mem_rsp.done)
         ld_q <= mem_rsp.rdata;
   end

endmodule

/* hdl/mips_top.sv */
`timescale 1ns/1ps

module mips_top
(
   input  logic                      clk,
   input  logic                      rst_b,
   output logic [mips_pkg::XLEN-1:0] paddr,
   output logic [mips_pkg::XLEN-1:0] pwdata,
   output logic                      pwrite,
   output logic                      psel,
   output logic                      penable,
   input  logic [mips_pkg::XLEN-1:0] prdata,
   input  logic                      pready,
   output logic                      halted
);

   // peers toward the arbiter
   logic                        f_valid;
   mips_pkg::bus_req_t          f_req;
   mips_pkg::bus_rsp_t          f_rsp;
   logic                        d_valid;
   mips_pkg::bus_req_t          d_req;
   mips_pkg::bus_rsp_t          d_rsp;

   // fetch to control
   logic                        inst_valid;
   logic                        inst_ready;
   mips_pkg::inst_t             inst;
   logic [mips_pkg::XLEN-1:0]   inst_pc;
   logic                        redirect;
   logic [mips_pkg::XLEN-1:0]   redirect_pc;

   // control to lsu
   logic                        mem_valid;
   mips_pkg::bus_req_t          mem_req;
   mips_pkg::bus_rsp_t          mem_rsp;

   // register file and alu
   logic [mips_pkg::REG_AW-1:0] rs_idx;
   logic [mips_pkg::REG_AW-1:0] rt_idx;
   logic [mips_pkg::REG_AW-1:0] wr_idx;
   logic [mips_pkg::XLEN-1:0]   rs_data;
   logic [mips_pkg::XLEN-1:0]   rt_data;
   logic                        wr_en;
   logic [mips_pkg::XLEN-1:0]   wr_data;
   mips_pkg::alu_op_e           alu_op;
   logic [mips_pkg::XLEN-1:0]   alu_a;
   logic [mips_pkg::XLEN-1:0]   alu_b;
   logic [mips_pkg::XLEN-1:0]   alu_y;
   logic                        alu_zero;

   fetch_unit fetch_i (
      .clk(clk), .rst_b(rst_b),
      .bus_valid(f_valid), .bus_req(f_req), .bus_rsp(f_rsp),
      .inst_valid(inst_valid), .inst(inst), .inst_pc(inst_pc), .inst_ready(inst_ready),
      .redirect(redirect), .redirect_pc(redirect_pc)
   );

   lsu lsu_i (
      .clk(clk), .rst_b(rst_b),
      .mem_valid(mem_valid), .mem_req(mem_req), .mem_rsp(mem_rsp),
      .bus_valid(d_valid), .bus_req(d_req), .bus_rsp(d_rsp)
   );

   apb_arbiter arb_i (
      .clk(clk), .rst_b(rst_b),
      .fetch_valid(f_valid), .fetch_req(f_req), .fetch_rsp(f_rsp),
      .data_valid(d_valid), .data_req(d_req), .data_rsp(d_rsp),
      .paddr(paddr), .pwrite(pwrite), .pwdata(pwdata),
      .psel(psel), .penable(penable), .prdata(prdata), .pready(pready)
   );

   core_ctrl ctrl_i (
      .clk(clk), .rst_b(rst_b),
      .inst_valid(inst_valid), .inst(inst), .inst_pc(inst_pc), .inst_ready(inst_ready),
      .redirect(redirect), .redirect_pc(redirect_pc),
      .mem_valid(mem_valid), .mem_req(mem_req), .mem_rsp(mem_rsp),
      .rs_idx(rs_idx), .rt_idx(rt_idx), .wr_idx(wr_idx),
      .rs_data(rs_data), .rt_data(rt_data), .wr_en(wr_en), .wr_data(wr_data),
      .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b), .alu_y(alu_y), .alu_zero(alu_zero),
      .halted(halted)
   );

   alu alu_i (
      .op(alu_op), .a(alu_a), .b(alu_b), .y(alu_y), .zero(alu_zero)
   );

   regfile regs_i (
      .clk(clk), .rst_b(rst_b),
      .rs_idx(rs_idx), .rt_idx(rt_idx), .wr_idx(wr_idx),
      .rs_data(rs_data), .rt_data(rt_data), .wr_en(wr_en), .wr_data(wr_data)
   );

endmodule

/* sim/tb_mips.sv */
`timescale 1ns/1ps

module tb_mips;

   // text segment ends below the data segment
   localparam logic [31:0] TEXT_END  = 32'h1000_0000;

   logic        clk = 1'b0;
   logic        rst_b;
   logic [31:0] paddr;
   logic [31:0] pwdata;
   logic        pwrite;
   logic        psel;
   logic        penable;
   logic [31:0] prdata;
   logic        pready;
   logic        halted;

   // memory model contents keyed by byte address
   logic [31:0] mem [logic [31:0]];
   logic [31:0] exp_addr [$];
   logic [31:0] exp_data [$];
   int          prog_words = 0;
   int          cycle_limit = 1000;
   int          cycles = 0;

   // transfer fields captured in the setup phase
   logic [31:0] setup_addr;
   logic        setup_write;
   logic [31:0] setup_wdata;
   logic [1:0]  wait_left;
   logic [15:0] lfsr = 16'd8961;

   mips_top dut_i (
      .clk(clk), .rst_b(rst_b),
      .paddr(paddr), .pwdata(pwdata), .pwrite(pwrite),
      .psel(psel), .penable(penable), .prdata(prdata), .pready(pready),
      .halted(halted)
   );

   always #4 clk = ~clk;

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp)
      begin
         $display("[ERROR] t=%0d ns: %s, got %h expected %h", $time, what, got, exp);
         $display("Something failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   // galois form with taps for x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // one lfsr step per bit for 0 to 3 wait states
   task automatic draw_wait_states(output logic [1:0] n);
      n = 2'd0;
      for (int k = 0; k < 2; k++)
      begin
         lfsr = lfsr_step(lfsr);
         n = {n[0], lfsr[0]};
      end
   endtask

   // words never written read back as an address dependent pattern
   function automatic logic [31:0] mem_word(input logic [31:0] a);
      if (mem.exists(a))
         mem_word = mem[a];
      else
         mem_word = a ^ 32'h5A5A_A5A5;
   endfunction

   // store targets of the program are the words listed as expected
   function automatic logic is_expected_addr(input logic [31:0] a);
      is_expected_addr = 1'b0;
      foreach (exp_addr[k])
         if (exp_addr[k] == a)
            is_expected_addr = 1'b1;
   endfunction

   task automatic load_stim();
      int          fd;
      int          n;
      string       line;
      logic [7:0]  kind;
      logic [31:0] a;
      logic [31:0] d;
      fd = $fopen("sim/prog_stim.txt", "r");
      if (fd == 0)
      begin
         $display("could not open the stim file sim/prog_stim.txt");
         $display("Something failed");
         $fatal(1, "no stimulus");
      end
      while ($fgets(line, fd) != 0)
      begin
         // skip comment and blank lines
         if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n")
            continue;
         n = $sscanf(line, "%c %h %h", kind, a, d);
         if (n == 3 && kind == "M")
         begin
            mem[a] = d;
            if (a >= mips_pkg::TEXT_START && a < TEXT_END)
               prog_words++;
         end
         else if (n == 3 && kind == "E")
         begin
            exp_addr.push_back(a);
            exp_data.push_back(d);
         end
         else
         begin
            $display("the stim file has a line that cannot be parsed: %s", line);
            $display("Something failed");
            $fatal(1, "bad stimulus");
         end
      end
      $fclose(fd);
      cycle_limit = 24 * prog_words + 100;
   endtask

   // apb slave and protocol monitor sampling between edges
   always @(negedge clk)
   begin
      if (rst_b)
      begin
         check({31'b0, penable && !psel}, 32'd0, "penable high without psel");
         if (psel && !penable)
         begin
            // a new transfer may not start once the core has halted
            check({31'b0, halted}, 32'd0, "apb transfer started after halt");
            setup_addr  = paddr;
            setup_write = pwrite;
            setup_wdata = pwdata;
            draw_wait_states(wait_left);
            pready = 1'b0;
         end
         else if (psel && penable)
         begin
            check(paddr, setup_addr, "paddr changed during transfer");
            check({31'b0, pwrite}, {31'b0, setup_write}, "pwrite changed during transfer");
            check(pwdata, setup_wdata, "pwdata changed during transfer");
            if (wait_left == 2'd0)
            begin
               if (pwrite)
               begin
                  // only aligned words named in the stim file may be written
                  check({31'b0, is_expected_addr(paddr)}, 32'd1,
                        "write to a word outside the expected set");
                  mem[paddr] = pwdata;
               end
               else
                  prdata = mem_word(paddr);
               pready = 1'b1;
            end
            else
            begin
               wait_left = wait_left - 2'd1;
               pready = 1'b0;
            end
         end
         else
            pready = 1'b0;
      end
   end

   // run length guard with the limit set once the program is loaded
   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles > cycle_limit)
      begin
         $display("timeout: the core did not finish within %0d cycles", cycle_limit);
         $display("Something failed");
         $fatal(1, "timeout");
      end
   end

   initial
   begin
      rst_b  = 1'b0;
      prdata = 32'd0;
      pready = 1'b0;
      load_stim();
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_b = 1'b1;
      // syscall ends the program
      while (!halted)
         @(negedge clk);
      // bus must stay quiet after the halt
      repeat (20) @(negedge clk);
      check({31'b0, halted}, 32'd1, "halted dropped after syscall");
      for (int k = 0; k < exp_addr.size(); k++)
         check(mem_word(exp_addr[k]), exp_data[k], $sformatf("memory word %h", exp_addr[k]));
      $display("Everything OK");
      $finish;
   end

endmodule

/* sim.f */
hdl/mips_pkg.sv
hdl/alu.sv
hdl/regfile.sv
hdl/lsu.sv
hdl/fetch_unit.sv
hdl/apb_arbiter.sv
hdl/core_ctrl.sv
hdl/mips_top.sv
sim/tb_mips.sv

/* Makefile */
# Verilator flow for the multicycle MIPS core
VERILATOR ?= verilator
TOP       ?= tb_mips
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Everything OK

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# the run passes only if the pass line shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* sim/prog_stim.txt */
# columns: kind address data, all hex
# kind M preloads the memory model, kind E is the word expected after halt
M 00400000 3C081001
M 00400004 24091234
M 00400008 240AFFFB
M 0040000C 352BF0F0
M 00400010 012A6021
M 00400014 AD0C0000
M 00400018 012A6823
M 0040001C AD0D0004
M 00400020 016A7024
M 00400024 AD0E0008
M 00400028 012C7825
M 0040002C AD0F000C
M 00400030 014B8026
M 00400034 AD100010
M 00400038 01208827
M 0040003C AD110014
M 00400040 0149902A
M 00400044 AD120018
M 00400048 012A982A
M 0040004C AD13001C
M 00400050 8D140040
M 00400054 8D150044
M 00400058 0295B021
M 0040005C AD160048
M 00400060 0295B823
M 00400064 AD17004C
M 00400068 11290001
M 0040006C AD090080
M 00400070 15290001
M 00400074 AD090084
M 00400078 152A0001
M 0040007C AD0A0088
M 00400080 112A0001
M 00400084 AD0A008C
M 00400088 08100024
M 0040008C AD090090
M 00400090 AD0B0094
M 00400094 0000000C
M 00400098 AD090098
M 1001001C DEADBEEF
M 10010040 00000100
M 10010044 00000023
M 10010080 A5A5A5A5
M 10010088 A5A5A5A5
M 10010090 A5A5A5A5
M 10010098 A5A5A5A5
E 10010000 0000122F
E 10010004 00001239
E 10010008 0000F2F0
E 1001000C 0000123F
E 10010010 FFFF0D0F
E 10010014 FFFFEDCB
E 10010018 00000001
E 1001001C 00000000
E 10010048 00000123
E 1001004C 000000DD
E 10010080 A5A5A5A5
E 10010084 00001234
E 10010088 A5A5A5A5
E 1001008C FFFFFFFB
E 10010090 A5A5A5A5
E 10010094 0000F2F4
E 10010098 A5A5A5A5
